// File: all.f
save_geom_pkg.sv
save_ctrl_pkg.sv
bank_port_if.sv
cart_save_bank.sv
save_policy.sv
save_sequencer.sv
save_top.sv
tb_save_top.sv

// File: bank_port_if.sv
//////////////////////////////////////////////////
// Word-wide RAM access port
// Initiator drives address and write data
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface bank_port_if;

	save_geom_pkg::bank_addr_t addr;
	save_geom_pkg::word_t      wdata;
	logic                      wr;
	save_geom_pkg::word_t      rdata;

	modport initiator (
		output addr,
		output wdata,
		output wr,
		input  rdata
	);

	modport target (
		input  addr,
		input  wdata,
		input  wr,
		output rdata
	);

endinterface

// File: cart_save_bank.sv
//////////////////////////////////////////////////
// Cartridge save RAM for one console
// Dual-port, console side and host side,
// registered read data on both ports
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cart_save_bank (
	input logic         clk_sys,
	bank_port_if.target console,
	bank_port_if.target host
);

	save_geom_pkg::word_t mem [save_geom_pkg::BANK_SECTORS * save_geom_pkg::SECTOR_WORDS];

	//////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////

	// Host write comes last so it wins on an address clash
	always_ff @(posedge clk_sys) begin
		if (console.wr) begin
			mem[console.addr] <= console.wdata;
		end
		if (host.wr) begin
			mem[host.addr] <= host.wdata;
		end
	end

	//////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////

	// One cycle from address to data on each port
	always_ff @(posedge clk_sys) begin
		console.rdata <= mem[console.addr];
	end

	always_ff @(posedge clk_sys) begin
		host.rdata <= mem[host.addr];
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the save controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_save_top -o tb_save_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_save_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1

// File: save_ctrl_pkg.sv
//////////////////////////////////////////////////
// Save controller types
// State encoding of the sector sequencer
//////////////////////////////////////////////////

package save_ctrl_pkg;

	// SEQ_LOAD moves host sectors into the banks
	// SEQ_SAVE moves bank contents out to the host
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_LOAD,
		SEQ_SAVE
	} seq_state_t;

endpackage

// File: save_geom_pkg.sv
//////////////////////////////////////////////////
// Save image and RAM geometry
// Sector and bank sizes, last sector numbers,
// vector types for words, addresses and sizes
//////////////////////////////////////////////////

package save_geom_pkg;

	// Words in one host sector
	localparam int SECTOR_WORDS = 16;

	// Sectors held by one console's save RAM
	localparam int BANK_SECTORS = 8;

	// Last sector of a full image covering both consoles
	localparam int LBA_LAST = 15;

	// Last sector when one half-size image feeds both consoles
	localparam int LBA_LAST_DUPE = 7;

	typedef logic [15:0] word_t;
	typedef logic [3:0]  buff_addr_t;
	typedef logic [2:0]  sector_idx_t;

	// Top bit picks the console
	typedef logic [3:0]  lba_t;

	typedef logic [6:0]  bank_addr_t;
	typedef logic [63:0] img_size_t;

endpackage

// File: save_policy.sv
//////////////////////////////////////////////////
// Backup RAM transfer policy
// Save enable, load and save requests,
// unsaved-write tracking, start pulses
//////////////////////////////////////////////////

`timescale 1ns/1ps

module save_policy (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cart_download,
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  save_geom_pkg::img_size_t img_size,
	input  logic                    cart1_has_save,
	input  logic                    cart2_has_save,
	input  logic                    cram1_wr,
	input  logic                    cram2_wr,
	input  logic                    load_btn,
	input  logic                    save_btn,
	input  logic                    autosave_en,
	input  logic                    osd_open,
	input  logic                    busy,
	output logic                    start_load,
	output logic                    start_save,
	output logic                    save_pending
);

	logic bk_ena;
	logic new_load;
	logic old_download;
	logic old_load;
	logic old_save;

	logic sav_supported;
	logic dl_begin;
	logic dl_end;
	logic load_req;
	logic save_req;
	logic load_edge;
	logic save_edge;
	logic auto_load;
	logic may_start;
	logic want_load;

	assign sav_supported = bk_ena & (cart1_has_save | cart2_has_save);

	assign dl_begin = ~old_download & cart_download;
	assign dl_end   = old_download & ~cart_download;

	assign load_req = load_btn | new_load;
	assign save_req = save_btn | (autosave_en & osd_open & save_pending);

	assign load_edge = ~old_load & load_req;
	assign save_edge = ~old_save & save_req;

	// Image with content present when the download finishes
	assign auto_load = dl_end & (|img_size);

	// A pulse just issued blocks a second one until busy rises
	assign may_start = bk_ena & ~busy & ~start_load & ~start_save;
	assign want_load = load_edge | auto_load;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena       <= 1'b0;
			new_load     <= 1'b0;
			old_download <= 1'b0;
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			save_pending <= 1'b0;
			start_load   <= 1'b0;
			start_save   <= 1'b0;
		end else begin
			old_download <= cart_download;
			old_load     <= load_req;
			old_save     <= save_req;

			// Save image gets mounted near the end of a download
			if (dl_begin) begin
				bk_ena <= 1'b0;
			end
			if (cart_download & img_mounted & ~img_readonly) begin
				bk_ena <= 1'b1;
			end

			if (dl_end & sav_supported) begin
				new_load <= 1'b1;
			end else if (busy) begin
				new_load <= 1'b0;
			end

			// Writes made from the menu do not count as game progress
			if ((cram1_wr | cram2_wr) & ~osd_open & sav_supported) begin
				save_pending <= 1'b1;
			end else if (busy) begin
				save_pending <= 1'b0;
			end

			// Load has priority over save
			start_load <= may_start & want_load;
			start_save <= may_start & ~want_load & save_edge;
		end
	end

endmodule

// File: save_sequencer.sv
//////////////////////////////////////////////////
// Save image sector sequencer
// Host block handshake, sector walk,
// word routing between host and both banks
//////////////////////////////////////////////////

`timescale 1ns/1ps

module save_sequencer (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      start_load,
	input  logic                      start_save,
	input  logic                      dupe_save,
	output logic                      busy,
	output logic                      bk_loading,

	output save_geom_pkg::lba_t       sd_lba,
	output logic                      sd_rd,
	output logic                      sd_wr,
	input  logic                      sd_ack,
	input  save_geom_pkg::buff_addr_t sd_buff_addr,
	input  save_geom_pkg::word_t      sd_buff_dout,
	input  logic                      sd_buff_wr,
	output save_geom_pkg::word_t      sd_buff_din,

	bank_port_if.initiator            bank1,
	bank_port_if.initiator            bank2
);

	localparam int LBA_MSB = $bits(save_geom_pkg::lba_t) - 1;

	save_ctrl_pkg::seq_state_t state;

	logic old_ack;
	logic ack_rise;
	logic ack_fall;
	logic last_sector;
	logic lba_hi;
	logic host_wr;

	save_geom_pkg::sector_idx_t sector;
	save_geom_pkg::bank_addr_t  bk_addr;

	//////////////////////////////////////////////////
	// Bank routing
	//////////////////////////////////////////////////

	assign lba_hi  = sd_lba[LBA_MSB];
	assign sector  = save_geom_pkg::sector_idx_t'(sd_lba[LBA_MSB-1:0]);
	assign bk_addr = {sector, sd_buff_addr};
	assign host_wr = sd_buff_wr & sd_ack;

	assign bank1.addr  = bk_addr;
	assign bank1.wdata = sd_buff_dout;
	assign bank1.wr    = ~lba_hi & host_wr;

	// In dupe mode the lower half also lands in console 2
	assign bank2.addr  = bk_addr;
	assign bank2.wdata = sd_buff_dout;
	assign bank2.wr    = (lba_hi | dupe_save) & host_wr;

	assign sd_buff_din = lba_hi ? bank2.rdata : bank1.rdata;

	//////////////////////////////////////////////////
	// Handshake and sector walk
	//////////////////////////////////////////////////

	assign ack_rise = ~old_ack & sd_ack;
	assign ack_fall = old_ack & ~sd_ack;

	assign last_sector = (sd_lba == save_geom_pkg::lba_t'(save_geom_pkg::LBA_LAST)) |
		(dupe_save & (sd_lba == save_geom_pkg::lba_t'(save_geom_pkg::LBA_LAST_DUPE)));

	assign busy = (state != save_ctrl_pkg::SEQ_IDLE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= save_ctrl_pkg::SEQ_IDLE;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
			old_ack    <= 1'b0;
		end else begin
			old_ack <= sd_ack;

			// Host took the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				save_ctrl_pkg::SEQ_IDLE: begin
					if (start_load) begin
						state      <= save_ctrl_pkg::SEQ_LOAD;
						sd_lba     <= '0;
						sd_rd      <= 1'b1;
						bk_loading <= 1'b1;
					end else if (start_save) begin
						state  <= save_ctrl_pkg::SEQ_SAVE;
						sd_lba <= '0;
						sd_wr  <= 1'b1;
					end
				end

				save_ctrl_pkg::SEQ_LOAD,
				save_ctrl_pkg::SEQ_SAVE: begin
					// At the end of a sector move on or stop
					if (ack_fall) begin
						if (last_sector) begin
							state      <= save_ctrl_pkg::SEQ_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= (state == save_ctrl_pkg::SEQ_LOAD);
							sd_wr  <= (state == save_ctrl_pkg::SEQ_SAVE);
						end
					end
				end

				default: begin
					state <= save_ctrl_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

// File: save_top.sv
//////////////////////////////////////////////////
// Backup RAM save and load controller top
// Policy, sequencer and two console save banks
//////////////////////////////////////////////////

`timescale 1ns/1ps

module save_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      cart_download,
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  save_geom_pkg::img_size_t  img_size,
	input  logic                      cart1_has_save,
	input  logic                      cart2_has_save,
	input  logic                      load_btn,
	input  logic                      save_btn,
	input  logic                      autosave_en,
	input  logic                      dupe_save,
	input  logic                      osd_open,

	// Console 1 cartridge RAM
	input  save_geom_pkg::bank_addr_t cram1_addr,
	input  save_geom_pkg::word_t      cram1_wdata,
	input  logic                      cram1_wr,
	output save_geom_pkg::word_t      cram1_rdata,

	// Console 2 cartridge RAM
	input  save_geom_pkg::bank_addr_t cram2_addr,
	input  save_geom_pkg::word_t      cram2_wdata,
	input  logic                      cram2_wr,
	output save_geom_pkg::word_t      cram2_rdata,

	// Host block transfer
	output save_geom_pkg::lba_t       sd_lba,
	output logic                      sd_rd,
	output logic                      sd_wr,
	input  logic                      sd_ack,
	input  save_geom_pkg::buff_addr_t sd_buff_addr,
	input  save_geom_pkg::word_t      sd_buff_dout,
	input  logic                      sd_buff_wr,
	output save_geom_pkg::word_t      sd_buff_din,

	output logic                      save_pending,
	output logic                      bk_loading
);

	logic start_load;
	logic start_save;
	logic busy;

	bank_port_if cram1_port ();
	bank_port_if cram2_port ();
	bank_port_if host1_port ();
	bank_port_if host2_port ();

	// Console sides come straight from the pins
	assign cram1_port.addr  = cram1_addr;
	assign cram1_port.wdata = cram1_wdata;
	assign cram1_port.wr    = cram1_wr;
	assign cram1_rdata      = cram1_port.rdata;

	assign cram2_port.addr  = cram2_addr;
	assign cram2_port.wdata = cram2_wdata;
	assign cram2_port.wr    = cram2_wr;
	assign cram2_rdata      = cram2_port.rdata;

	save_policy policy0 (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cart_download  (cart_download),
		.img_mounted    (img_mounted),
		.img_readonly   (img_readonly),
		.img_size       (img_size),
		.cart1_has_save (cart1_has_save),
		.cart2_has_save (cart2_has_save),
		.cram1_wr       (cram1_wr),
		.cram2_wr       (cram2_wr),
		.load_btn       (load_btn),
		.save_btn       (save_btn),
		.autosave_en    (autosave_en),
		.osd_open       (osd_open),
		.busy           (busy),
		.start_load     (start_load),
		.start_save     (start_save),
		.save_pending   (save_pending)
	);

	save_sequencer seq0 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.start_load   (start_load),
		.start_save   (start_save),
		.dupe_save    (dupe_save),
		.busy         (busy),
		.bk_loading   (bk_loading),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_din  (sd_buff_din),
		.bank1        (host1_port.initiator),
		.bank2        (host2_port.initiator)
	);

	cart_save_bank bank1 (
		.clk_sys (clk_sys),
		.console (cram1_port.target),
		.host    (host1_port.target)
	);

	cart_save_bank bank2 (
		.clk_sys (clk_sys),
		.console (cram2_port.target),
		.host    (host2_port.target)
	);

endmodule

// File: tb_save_top.sv
//////////////////////////////////////////////////
// Testbench for the backup RAM save controller
// Host block-transfer model, console port access,
// reference bank contents, checker and watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_save_top;

	localparam int WORDS       = save_geom_pkg::SECTOR_WORDS;
	localparam int BANK_WORDS  = save_geom_pkg::BANK_SECTORS * save_geom_pkg::SECTOR_WORDS;
	localparam int IMG_WORDS   = 2 * BANK_WORDS;
	localparam int START_WAIT  = 20;
	localparam int IDLE_WAIT   = 6;
	localparam int QUIET_WAIT  = 20;

	// Run length from 56 sectors moved, two bank read-backs, setup and waits
	localparam int SECTOR_CYCLES   = 24;
	localparam int SECTORS_TOTAL   = 16 + 8 + 16 + 16;
	localparam int WATCHDOG_CYCLES = 2 * (SECTORS_TOTAL * SECTOR_CYCLES + 2 * BANK_WORDS + 600);

	logic clk_sys;
	logic reset;
	logic cart_download;
	logic img_mounted;
	logic img_readonly;
	save_geom_pkg::img_size_t img_size;
	logic cart1_has_save;
	logic cart2_has_save;
	logic load_btn;
	logic save_btn;
	logic autosave_en;
	logic dupe_save;
	logic osd_open;
	save_geom_pkg::bank_addr_t cram1_addr;
	save_geom_pkg::word_t      cram1_wdata;
	logic                      cram1_wr;
	save_geom_pkg::word_t      cram1_rdata;
	save_geom_pkg::bank_addr_t cram2_addr;
	save_geom_pkg::word_t      cram2_wdata;
	logic                      cram2_wr;
	save_geom_pkg::word_t      cram2_rdata;
	save_geom_pkg::lba_t       sd_lba;
	logic                      sd_rd;
	logic                      sd_wr;
	logic                      sd_ack;
	save_geom_pkg::buff_addr_t sd_buff_addr;
	save_geom_pkg::word_t      sd_buff_dout;
	logic                      sd_buff_wr;
	save_geom_pkg::word_t      sd_buff_din;
	logic                      save_pending;
	logic                      bk_loading;

	// Expected bank contents and the host's image
	save_geom_pkg::word_t exp_bank1 [BANK_WORDS];
	save_geom_pkg::word_t exp_bank2 [BANK_WORDS];
	save_geom_pkg::word_t img [IMG_WORDS];

	logic [31:0] lfsr_state = 32'h990e916c;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed_tests = 0;

	save_top dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic save_geom_pkg::word_t lfsr_word();
		save_geom_pkg::word_t w;
		logic fb;
		w = '0;
		for (int b = 0; b < 16; b++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			w = {w[14:0], fb};
		end
		return w;
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error: %s", what);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic fill_image();
		for (int i = 0; i < IMG_WORDS; i++) begin
			img[i] = lfsr_word();
		end
	endtask

	task automatic wait_request(input int max_cycles, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < max_cycles) begin
			next_cycle();
			n++;
			if (sd_rd | sd_wr) begin
				seen = 1'b1;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Host model
	//////////////////////////////////////////////////

	task automatic serve_sector(input bit is_load, input int exp_lba);
		save_geom_pkg::lba_t lba;
		int base;
		lba = sd_lba;
		base = int'(lba[2:0]) * WORDS;
		check_value("sd_lba", lba, exp_lba);
		check_value("sd_rd", sd_rd, is_load);
		check_value("sd_wr", sd_wr, !is_load);
		check_value("bk_loading", bk_loading, is_load);

		// Host latency before it takes the request
		repeat (2) next_cycle();
		sd_ack = 1'b1;
		next_cycle();
		check_value("sd_rd | sd_wr after ack", sd_rd | sd_wr, 0);

		if (is_load) begin
			for (int i = 0; i < WORDS; i++) begin
				sd_buff_addr = save_geom_pkg::buff_addr_t'(i);
				sd_buff_dout = img[int'(lba) * WORDS + i];
				sd_buff_wr   = 1'b1;
				if (!lba[3]) begin
					exp_bank1[base + i] = sd_buff_dout;
				end
				if (lba[3] || dupe_save) begin
					exp_bank2[base + i] = sd_buff_dout;
				end
				next_cycle();
			end
			sd_buff_wr = 1'b0;
		end else begin
			// Read data trails the word address by one cycle
			sd_buff_addr = '0;
			for (int i = 1; i <= WORDS; i++) begin
				next_cycle();
				check_value($sformatf("sd_buff_din lba %0d word %0d", lba, i - 1), sd_buff_din,
					lba[3] ? exp_bank2[base + i - 1] : exp_bank1[base + i - 1]);
				if (i < WORDS) begin
					sd_buff_addr = save_geom_pkg::buff_addr_t'(i);
				end
			end
		end
		sd_ack = 1'b0;
	endtask

	task automatic run_transfer(input bit is_load, input int last_lba);
		bit seen;
		int sectors;
		sectors = 0;
		wait_request(START_WAIT, seen);
		if (!seen) begin
			report_failure("no host request at the start of the transfer");
		end
		while (seen && sectors < 32) begin
			serve_sector(is_load, sectors);
			sectors++;
			wait_request(IDLE_WAIT, seen);
		end
		check_value("sectors moved", sectors, last_lba + 1);
		check_value("bk_loading", bk_loading, 0);
	endtask

	//////////////////////////////////////////////////
	// Console side
	//////////////////////////////////////////////////

	task automatic write_console(input bit second, input int addr, input save_geom_pkg::word_t w);
		if (second) begin
			cram2_addr  = save_geom_pkg::bank_addr_t'(addr);
			cram2_wdata = w;
			cram2_wr    = 1'b1;
			exp_bank2[addr] = w;
		end else begin
			cram1_addr  = save_geom_pkg::bank_addr_t'(addr);
			cram1_wdata = w;
			cram1_wr    = 1'b1;
			exp_bank1[addr] = w;
		end
		next_cycle();
		cram1_wr = 1'b0;
		cram2_wr = 1'b0;
	endtask

	task automatic check_banks();
		for (int a = 0; a < BANK_WORDS; a++) begin
			cram1_addr = save_geom_pkg::bank_addr_t'(a);
			cram2_addr = save_geom_pkg::bank_addr_t'(a);
			next_cycle();
			check_value($sformatf("cram1_rdata[%0d]", a), cram1_rdata, exp_bank1[a]);
			check_value($sformatf("cram2_rdata[%0d]", a), cram2_rdata, exp_bank2[a]);
		end
	endtask

	task automatic download_cart(input bit readonly);
		cart_download = 1'b1;
		img_readonly  = readonly;
		img_size      = 64'h2000;
		next_cycle();
		img_mounted = 1'b1;
		next_cycle();
		img_mounted = 1'b0;
		next_cycle();
		cart_download = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_console_ports();
		int e0;
		int addr;
		save_geom_pkg::word_t w1;
		save_geom_pkg::word_t w2;
		e0 = errors;
		for (int k = 0; k < 8; k++) begin
			addr = (k * 17) % BANK_WORDS;
			w1 = lfsr_word();
			w2 = lfsr_word();
			if (w2 == w1) begin
				w2 = ~w1;
			end
			// Both consoles write the same address on the same edge
			cram2_addr  = save_geom_pkg::bank_addr_t'(addr);
			cram2_wdata = w2;
			cram2_wr    = 1'b1;
			exp_bank2[addr] = w2;
			write_console(1'b0, addr, w1);
		end
		for (int k = 0; k < 8; k++) begin
			addr = (k * 17) % BANK_WORDS;
			cram1_addr = save_geom_pkg::bank_addr_t'(addr);
			cram2_addr = save_geom_pkg::bank_addr_t'(addr);
			next_cycle();
			check_value("cram1_rdata", cram1_rdata, exp_bank1[addr]);
			check_value("cram2_rdata", cram2_rdata, exp_bank2[addr]);
		end
		finish_test("console_ports", e0);
	endtask

	task automatic test_auto_load();
		int e0;
		e0 = errors;
		fill_image();
		cart1_has_save = 1'b1;
		download_cart(1'b0);
		run_transfer(1'b1, save_geom_pkg::LBA_LAST);
		check_banks();
		finish_test("auto_load", e0);
	endtask

	task automatic test_dupe_load();
		int e0;
		e0 = errors;
		fill_image();
		dupe_save = 1'b1;
		load_btn  = 1'b1;
		next_cycle();
		load_btn = 1'b0;
		run_transfer(1'b1, save_geom_pkg::LBA_LAST_DUPE);
		dupe_save = 1'b0;
		check_banks();
		finish_test("dupe_load", e0);
	endtask

	task automatic test_manual_save();
		int e0;
		e0 = errors;
		// Menu writes make bank 2 differ from bank 1 but do not count as unsaved
		osd_open = 1'b1;
		for (int a = 0; a < WORDS; a++) begin
			write_console(1'b1, a, lfsr_word());
		end
		next_cycle();
		check_value("save_pending", save_pending, 0);
		osd_open = 1'b0;
		save_btn = 1'b1;
		next_cycle();
		save_btn = 1'b0;
		run_transfer(1'b0, save_geom_pkg::LBA_LAST);
		finish_test("manual_save", e0);
	endtask

	task automatic test_autosave();
		int e0;
		bit seen;
		e0 = errors;
		autosave_en = 1'b1;
		write_console(1'b0, 5, lfsr_word());
		check_value("save_pending", save_pending, 1);
		// No autosave while the menu stays closed
		wait_request(IDLE_WAIT, seen);
		if (seen) begin
			report_failure("autosave started while the menu was closed");
		end
		osd_open = 1'b1;
		run_transfer(1'b0, save_geom_pkg::LBA_LAST);
		check_value("save_pending", save_pending, 0);
		osd_open    = 1'b0;
		autosave_en = 1'b0;
		finish_test("autosave", e0);
	endtask

	task automatic test_readonly();
		int e0;
		bit seen;
		e0 = errors;
		download_cart(1'b1);
		wait_request(QUIET_WAIT, seen);
		if (seen) begin
			report_failure("host request after a download with a read-only image");
		end
		load_btn = 1'b1;
		next_cycle();
		load_btn = 1'b0;
		wait_request(QUIET_WAIT, seen);
		if (seen) begin
			report_failure("load button started a transfer with saving disabled");
		end
		save_btn = 1'b1;
		next_cycle();
		save_btn = 1'b0;
		wait_request(QUIET_WAIT, seen);
		if (seen) begin
			report_failure("save button started a transfer with saving disabled");
		end
		finish_test("readonly", e0);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		reset          = 1'b1;
		cart_download  = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		cart1_has_save = 1'b0;
		cart2_has_save = 1'b0;
		load_btn       = 1'b0;
		save_btn       = 1'b0;
		autosave_en    = 1'b0;
		dupe_save      = 1'b0;
		osd_open       = 1'b0;
		cram1_addr     = '0;
		cram1_wdata    = '0;
		cram1_wr       = 1'b0;
		cram2_addr     = '0;
		cram2_wdata    = '0;
		cram2_wr       = 1'b0;
		sd_ack         = 1'b0;
		sd_buff_addr   = '0;
		sd_buff_dout   = '0;
		sd_buff_wr     = 1'b0;

		repeat (5) next_cycle();
		reset = 1'b0;
		next_cycle();
		check_value("sd_rd", sd_rd, 0);
		check_value("sd_wr", sd_wr, 0);
		check_value("bk_loading", bk_loading, 0);
		check_value("save_pending", save_pending, 0);

		test_console_ports();
		test_auto_load();
		test_dupe_load();
		test_manual_save();
		test_autosave();
		test_readonly();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
